// File: src/bn_pkg.sv
package bn_pkg;

    // which parameter a write targets
    typedef enum logic [1:0] {
        SEL_GAMMA = 2'd0,
        SEL_BETA  = 2'd1,
        SEL_MEAN  = 2'd2,
        SEL_STDV  = 2'd3
    } param_sel_t;

    // folded gamma/stdv scale, twice the data width
    function automatic int scale_width(input int data_width);
        return 2 * data_width;
    endfunction

    // clamp to signed data_width range, caller casts the result down
    function automatic logic signed [63:0] sat_signed(input logic signed [63:0] value,
                                                      input int data_width);
        logic signed [63:0] max_val;
        logic signed [63:0] min_val;
        max_val = (64'sd1 <<< (data_width - 1)) - 64'sd1;
        min_val = -(64'sd1 <<< (data_width - 1));
        if (value > max_val)
            return max_val;
        if (value < min_val)
            return min_val;
        return value;
    endfunction

endpackage

// File: src/bn_scale_divider.sv
`timescale 1ns/1ns
module bn_scale_divider
    import bn_pkg::*;
#(
    parameter int DATA_WIDTH = 8,
    parameter int FRAC_WIDTH = 4
) (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic                                     start,
    input  logic signed [DATA_WIDTH-1:0]             gamma,
    input  logic        [DATA_WIDTH-1:0]             stdv,
    output logic                                     done,
    output logic signed [scale_width(DATA_WIDTH)-1:0] scale
);
    // quotient bits, one restoring step each
    localparam int QW = DATA_WIDTH + FRAC_WIDTH;
    localparam int SW = scale_width(DATA_WIDTH);
    localparam int CW = $clog2(QW + 1);

    logic [DATA_WIDTH-1:0] divisor_r;
    logic [DATA_WIDTH-1:0] rem_r;
    logic [QW-1:0]         quot_r;
    logic                  neg_r;
    logic                  busy_r;
    logic [CW-1:0]         count_r;

    logic [DATA_WIDTH-1:0] gamma_mag;
    logic [DATA_WIDTH:0]   rem_shift;
    logic [DATA_WIDTH+1:0] trial;
    logic [DATA_WIDTH-1:0] rem_next;
    logic [QW-1:0]         quot_next;
    logic [SW-1:0]         quot_ext;

    // magnitude, most negative gamma maps to 2^(DW-1) unsigned
    assign gamma_mag = gamma[DATA_WIDTH-1] ? (~gamma + 1'b1) : gamma;

    always_comb
    begin
        // bring down next dividend bit, try subtracting divisor
        rem_shift = {rem_r, quot_r[QW-1]};
        trial     = {1'b0, rem_shift} - {2'b00, divisor_r};
        if (!trial[DATA_WIDTH+1])
        begin
            rem_next  = trial[DATA_WIDTH-1:0];
            quot_next = {quot_r[QW-2:0], 1'b1};
        end
        else
        begin
            rem_next  = rem_shift[DATA_WIDTH-1:0];
            quot_next = {quot_r[QW-2:0], 1'b0};
        end
        quot_ext = SW'(quot_next);
    end

    // step counter and done pulse
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            busy_r  <= 1'b0;
            done    <= 1'b0;
            count_r <= '0;
        end
        else
        begin
            done <= 1'b0;
            if (start)
            begin
                busy_r  <= 1'b1;
                count_r <= CW'(QW);
            end
            else if (busy_r)
            begin
                count_r <= count_r - 1'b1;
                // last step, done shows next cycle
                if (count_r == CW'(1))
                begin
                    busy_r <= 1'b0;
                    done   <= 1'b1;
                end
            end
        end
    end

    // dividend is |gamma| << FRAC_WIDTH, shifted out msb first
    always_ff @(posedge clk)
    begin
        if (start)
        begin
            divisor_r <= stdv;
            rem_r     <= '0;
            quot_r    <= {gamma_mag, {FRAC_WIDTH{1'b0}}};
            neg_r     <= gamma[DATA_WIDTH-1];
        end
        else if (busy_r)
        begin
            rem_r  <= rem_next;
            quot_r <= quot_next;
            if (count_r == CW'(1))
            begin
                // zero stdv saturates by sign of gamma
                if (divisor_r == '0)
                    scale <= neg_r ? {1'b1, {(SW-1){1'b0}}} : {1'b0, {(SW-1){1'b1}}};
                else
                    scale <= neg_r ? -quot_ext : quot_ext;
            end
        end
    end

endmodule

// File: src/bn_param_store.sv
`timescale 1ns/1ns
module bn_param_store
    import bn_pkg::*;
#(
    parameter int CHANNELS   = 4,
    parameter int DATA_WIDTH = 8,
    parameter int FRAC_WIDTH = 4
) (
    input  logic                                          clk,
    input  logic                                          reset,
    input  logic                                          param_wr,
    input  param_sel_t                                    param_sel,
    input  logic [$clog2(CHANNELS)-1:0]                   param_chan,
    input  logic [DATA_WIDTH-1:0]                         param_data,
    output logic [CHANNELS*DATA_WIDTH-1:0]                mean_flat,
    output logic [CHANNELS*DATA_WIDTH-1:0]                beta_flat,
    output logic [CHANNELS*scale_width(DATA_WIDTH)-1:0]   scale_flat,
    output logic                                          params_ready
);
    localparam int SW = scale_width(DATA_WIDTH);
    localparam int CHW = $clog2(CHANNELS);

    logic signed [DATA_WIDTH-1:0] gamma_r [CHANNELS];
    logic signed [DATA_WIDTH-1:0] beta_r  [CHANNELS];
    logic signed [DATA_WIDTH-1:0] mean_r  [CHANNELS];
    logic        [DATA_WIDTH-1:0] stdv_r  [CHANNELS];
    logic signed [SW-1:0]         scale_r [CHANNELS];

    logic [CHANNELS-1:0] dirty_r;
    logic                busy_r;
    logic [CHW-1:0]      cur_chan_r;
    // channel rewritten while its fold runs
    logic                stale_r;

    logic                fold_wr;
    logic [CHW-1:0]      next_chan;
    logic                div_start;
    logic                div_done;
    logic signed [SW-1:0] div_scale;

    // gamma or stdv change needs a refold
    assign fold_wr = param_wr && (param_sel == SEL_GAMMA || param_sel == SEL_STDV);

    // lowest dirty channel wins
    always_comb
    begin
        next_chan = '0;
        for (int i = CHANNELS - 1; i >= 0; i--)
        begin
            if (dirty_r[i])
                next_chan = CHW'(i);
        end
    end

    assign div_start    = !busy_r && (|dirty_r);
    assign params_ready = !(|dirty_r) && !busy_r;

    bn_scale_divider #(
        .DATA_WIDTH (DATA_WIDTH),
        .FRAC_WIDTH (FRAC_WIDTH)
    ) divider0 (
        .clk   (clk),
        .reset (reset),
        .start (div_start),
        .gamma (gamma_r[next_chan]),
        .stdv  (stdv_r[next_chan]),
        .done  (div_done),
        .scale (div_scale)
    );

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < CHANNELS; i++)
            begin
                gamma_r[i] <= '0;
                beta_r[i]  <= '0;
                mean_r[i]  <= '0;
                stdv_r[i]  <= '0;
                scale_r[i] <= '0;
            end
            dirty_r    <= '0;
            busy_r     <= 1'b0;
            cur_chan_r <= '0;
            stale_r    <= 1'b0;
        end
        else
        begin
            if (param_wr)
            begin
                case (param_sel)
                    SEL_GAMMA: gamma_r[param_chan] <= param_data;
                    SEL_BETA:  beta_r[param_chan]  <= param_data;
                    SEL_MEAN:  mean_r[param_chan]  <= param_data;
                    SEL_STDV:  stdv_r[param_chan]  <= param_data;
                    default: ;
                endcase
            end
            // result is kept only if nothing touched the channel meanwhile
            if (div_done)
            begin
                busy_r <= 1'b0;
                if (!stale_r && !(fold_wr && param_chan == cur_chan_r))
                begin
                    scale_r[cur_chan_r] <= div_scale;
                    dirty_r[cur_chan_r] <= 1'b0;
                end
            end
            // a new write overrides the clear above
            if (fold_wr)
                dirty_r[param_chan] <= 1'b1;
            if (div_start)
            begin
                busy_r     <= 1'b1;
                cur_chan_r <= next_chan;
                // write on the start edge, divider took the old value
                stale_r    <= fold_wr && param_chan == next_chan;
            end
            else if (busy_r && fold_wr && param_chan == cur_chan_r)
                stale_r <= 1'b1;
        end
    end

    // pack per-channel values, channel 0 low
    always_comb
    begin
        for (int i = 0; i < CHANNELS; i++)
        begin
            mean_flat[i*DATA_WIDTH +: DATA_WIDTH] = mean_r[i];
            beta_flat[i*DATA_WIDTH +: DATA_WIDTH] = beta_r[i];
            scale_flat[i*SW +: SW]                = scale_r[i];
        end
    end

endmodule

// File: src/bn_norm_lane.sv
`timescale 1ns/1ns
module bn_norm_lane
    import bn_pkg::*;
#(
    parameter int DATA_WIDTH = 8,
    parameter int FRAC_WIDTH = 4
) (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic                                     valid_in,
    input  logic signed [DATA_WIDTH-1:0]             x,
    input  logic signed [DATA_WIDTH-1:0]             mean,
    input  logic signed [scale_width(DATA_WIDTH)-1:0] scale,
    input  logic signed [DATA_WIDTH-1:0]             beta,
    output logic                                     valid_out,
    output logic signed [DATA_WIDTH-1:0]             y
);
    localparam int SW = scale_width(DATA_WIDTH);
    // product width, diff is one bit wider than data
    localparam int PW = DATA_WIDTH + 1 + SW;

    logic signed [DATA_WIDTH:0] diff;
    logic signed [PW-1:0]       prod;
    logic signed [PW-1:0]       prod_r;
    logic                       valid_r;
    logic signed [PW-1:0]       shifted;
    logic signed [PW:0]         sum;

    // stage 1 arithmetic, no overflow at full width
    assign diff = {x[DATA_WIDTH-1], x} - {mean[DATA_WIDTH-1], mean};
    assign prod = diff * scale;

    // stage 2 arithmetic, arithmetic shift floors
    assign shifted = prod_r >>> FRAC_WIDTH;
    assign sum     = shifted + beta;

    // stage 1: product and valid
    always_ff @(posedge clk)
    begin
        if (reset)
            valid_r <= 1'b0;
        else
            valid_r <= valid_in;
    end

    always_ff @(posedge clk)
    begin
        prod_r <= prod;
    end

    // stage 2: add beta, clamp, register result
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            valid_out <= 1'b0;
            y         <= '0;
        end
        else
        begin
            valid_out <= valid_r;
            if (valid_r)
                y <= DATA_WIDTH'(sat_signed(sum, DATA_WIDTH));
        end
    end

endmodule

// File: src/bn_batch_norm1d.sv
`timescale 1ns/1ns
module bn_batch_norm1d
    import bn_pkg::*;
#(
    parameter int CHANNELS   = 4,
    parameter int DATA_WIDTH = 8,
    parameter int FRAC_WIDTH = 4
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           in_valid,
    input  logic [CHANNELS*DATA_WIDTH-1:0] in_data,
    output logic                           out_valid,
    output logic [CHANNELS*DATA_WIDTH-1:0] out_data,
    input  logic                           param_wr,
    input  param_sel_t                     param_sel,
    input  logic [$clog2(CHANNELS)-1:0]    param_chan,
    input  logic [DATA_WIDTH-1:0]          param_data,
    output logic                           params_ready
);
    localparam int SW = scale_width(DATA_WIDTH);

    logic [CHANNELS*DATA_WIDTH-1:0] mean_flat;
    logic [CHANNELS*DATA_WIDTH-1:0] beta_flat;
    logic [CHANNELS*SW-1:0]         scale_flat;
    // every lane carries the same valid
    logic [CHANNELS-1:0]            lane_valid;

    // parameters, folded scales, fold sequencing
    bn_param_store #(
        .CHANNELS   (CHANNELS),
        .DATA_WIDTH (DATA_WIDTH),
        .FRAC_WIDTH (FRAC_WIDTH)
    ) store0 (
        .clk          (clk),
        .reset        (reset),
        .param_wr     (param_wr),
        .param_sel    (param_sel),
        .param_chan   (param_chan),
        .param_data   (param_data),
        .mean_flat    (mean_flat),
        .beta_flat    (beta_flat),
        .scale_flat   (scale_flat),
        .params_ready (params_ready)
    );

    // one lane per channel, channel 0 in the low bits
    for (genvar i = 0; i < CHANNELS; i++)
    begin : g_lane
        bn_norm_lane #(
            .DATA_WIDTH (DATA_WIDTH),
            .FRAC_WIDTH (FRAC_WIDTH)
        ) lane (
            .clk       (clk),
            .reset     (reset),
            .valid_in  (in_valid),
            .x         (in_data[i*DATA_WIDTH +: DATA_WIDTH]),
            .mean      (mean_flat[i*DATA_WIDTH +: DATA_WIDTH]),
            .scale     (scale_flat[i*SW +: SW]),
            .beta      (beta_flat[i*DATA_WIDTH +: DATA_WIDTH]),
            .valid_out (lane_valid[i]),
            .y         (out_data[i*DATA_WIDTH +: DATA_WIDTH])
        );
    end

    assign out_valid = lane_valid[0];

endmodule

// File: verif/bn_batch_norm1d_props.sv
`timescale 1ns/1ns
module bn_batch_norm1d_props
    import bn_pkg::*;
(
    input logic       clk,
    input logic       reset,
    input logic       in_valid,
    input logic       out_valid,
    input logic       param_wr,
    input param_sel_t param_sel,
    input logic       params_ready
);
    // two stage lane, result exactly two cycles on
    assert property (@(posedge clk) disable iff (reset) in_valid |-> ##2 out_valid)
    else $error("out_valid missing two cycles after in_valid");

    assert property (@(posedge clk) disable iff (reset) out_valid |-> $past(in_valid, 2))
    else $error("out_valid without in_valid two cycles earlier");

    // state one cycle after a reset cycle
    assert property (@(posedge clk) reset |=> (!out_valid && params_ready))
    else $error("out_valid or params_ready not at reset state");

    // gamma or stdv write marks the channel dirty
    assert property (@(posedge clk) disable iff (reset)
        (param_wr && (param_sel == SEL_GAMMA || param_sel == SEL_STDV)) |=> !params_ready)
    else $error("params_ready still high after a gamma or stdv write");

endmodule

bind bn_batch_norm1d bn_batch_norm1d_props props0 (
    .clk          (clk),
    .reset        (reset),
    .in_valid     (in_valid),
    .out_valid    (out_valid),
    .param_wr     (param_wr),
    .param_sel    (param_sel),
    .params_ready (params_ready)
);

// File: verif/bn_batch_norm1d_tb.sv
`timescale 1ns/1ns
module bn_batch_norm1d_tb
    import bn_pkg::*;
();
    localparam int CH = 4;
    localparam int DW = 8;
    localparam int FW = 4;
    localparam int W = CH * DW;
    localparam int READY_TIMEOUT = 1000;
    localparam int DRAIN_TIMEOUT = 20;

    logic         clk;
    logic         reset;
    logic         in_valid;
    logic [W-1:0] in_data;
    logic         out_valid;
    logic [W-1:0] out_data;
    logic         param_wr;
    param_sel_t   param_sel;
    logic [1:0]   param_chan;
    logic [DW-1:0] param_data;
    logic         params_ready;

    // shadow parameter registers and folded scales
    int     gamma_m [CH];
    int     beta_m  [CH];
    int     mean_m  [CH];
    int     stdv_m  [CH];
    longint scale_m [CH];
    // one entry per sample in flight
    logic [W-1:0] expected_q [$];
    logic [31:0]  rng_state;

    bn_batch_norm1d dut0 (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .in_data      (in_data),
        .out_valid    (out_valid),
        .out_data     (out_data),
        .param_wr     (param_wr),
        .param_sel    (param_sel),
        .param_chan   (param_chan),
        .param_data   (param_data),
        .params_ready (params_ready)
    );

    always #10 clk = ~clk;

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    // xorshift32 step
    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // truncated |gamma| << frac / stdv with the sign of gamma
    function automatic longint fold_model(input int gamma, input int stdv);
        longint mag;
        longint q;
        mag = (gamma < 0) ? -gamma : gamma;
        // zero divisor saturates the 16 bit scale
        if (stdv == 0)
            return (gamma < 0) ? -32768 : 32767;
        q = (mag <<< FW) / stdv;
        return (gamma < 0) ? -q : q;
    endfunction

    function automatic logic [DW-1:0] lane_model(input int x, input int ch);
        longint p;
        longint sum;
        p = longint'(x - mean_m[ch]) * scale_m[ch];
        // floor shift then add beta
        sum = (p >>> FW) + beta_m[ch];
        return DW'(sat_signed(sum, DW));
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic idle(input int n);
        for (int i = 0; i < n; i++)
            next_cycle();
    endtask

    task automatic write_param(input param_sel_t sel, input int chan, input logic [DW-1:0] value);
        param_wr   = 1'b1;
        param_sel  = sel;
        param_chan = 2'(chan);
        param_data = value;
        case (sel)
            SEL_GAMMA: gamma_m[chan] = $signed(value);
            SEL_BETA:  beta_m[chan]  = $signed(value);
            SEL_MEAN:  mean_m[chan]  = $signed(value);
            default:   stdv_m[chan]  = value;
        endcase
        // last written gamma/stdv decides the scale
        if (sel == SEL_GAMMA || sel == SEL_STDV)
            scale_m[chan] = fold_model(gamma_m[chan], stdv_m[chan]);
        next_cycle();
        param_wr = 1'b0;
    endtask

    task automatic program_channel(input int ch);
        logic [DW-1:0] sd;
        write_param(SEL_GAMMA, ch, DW'(next_rand()));
        write_param(SEL_BETA, ch, DW'(next_rand()));
        write_param(SEL_MEAN, ch, DW'(next_rand()));
        sd = DW'(next_rand());
        if (sd == '0)
            sd = 8'd1;
        write_param(SEL_STDV, ch, sd);
    endtask

    task automatic send_sample(input logic [W-1:0] data);
        logic [W-1:0] exp;
        for (int ch = 0; ch < CH; ch++)
            exp[ch*DW +: DW] = lane_model($signed(data[ch*DW +: DW]), ch);
        in_valid = 1'b1;
        in_data  = data;
        expected_q.push_back(exp);
        next_cycle();
        in_valid = 1'b0;
    endtask

    // one sample per cycle back to back
    task automatic send_burst(input int n);
        for (int i = 0; i < n; i++)
            send_sample(W'(next_rand()));
    endtask

    // ready plus two cycles so mean and scale have settled
    task automatic wait_params_ready();
        int cycles;
        cycles = 0;
        while (!params_ready && cycles < READY_TIMEOUT)
        begin
            next_cycle();
            cycles++;
        end
        assert (params_ready)
        else stop_on_error("params_ready never rose after the parameter writes");
        idle(2);
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (expected_q.size() != 0 && cycles < DRAIN_TIMEOUT)
        begin
            next_cycle();
            cycles++;
        end
        assert (expected_q.size() == 0)
        else stop_on_error("expected outputs never appeared on out_valid");
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk)
    begin
        logic [W-1:0] exp;
        if (!reset && out_valid)
        begin
            assert (expected_q.size() != 0)
            else stop_on_error($sformatf("error at %0t ns: out_valid with no sample in flight",
                $time));
            exp = expected_q.pop_front();
            for (int ch = 0; ch < CH; ch++)
            begin
                assert (out_data[ch*DW +: DW] == exp[ch*DW +: DW])
                else stop_on_error($sformatf("error at %0t ns: lane %0d got %0d, expected %0d",
                    $time, ch, $signed(out_data[ch*DW +: DW]), $signed(exp[ch*DW +: DW])));
            end
        end
    end

    initial
    begin
        int delays [3];
        delays     = '{0, 4, 9};
        clk        = 1'b0;
        reset      = 1'b1;
        in_valid   = 1'b0;
        in_data    = '0;
        param_wr   = 1'b0;
        param_sel  = SEL_GAMMA;
        param_chan = '0;
        param_data = '0;
        rng_state  = 32'd31984;
        for (int ch = 0; ch < CH; ch++)
        begin
            gamma_m[ch] = 0;
            beta_m[ch]  = 0;
            mean_m[ch]  = 0;
            stdv_m[ch]  = 0;
            // reset scale is zero rather than the folded 0/0 value
            scale_m[ch] = 0;
        end
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        // after reset everything reads zero
        assert (params_ready)
        else stop_on_error($sformatf("error at %0t ns: params_ready low right after reset",
            $time));
        send_burst(4);
        wait_drain();

        // random parameters on every channel
        for (int ch = 0; ch < CH; ch++)
            program_channel(ch);
        wait_params_ready();
        send_burst(32);
        wait_drain();

        // big gamma over stdv of one with extreme inputs
        for (int ch = 0; ch < CH; ch++)
        begin
            write_param(SEL_GAMMA, ch, (ch % 2 == 0) ? 8'h7F : 8'h80);
            write_param(SEL_STDV, ch, 8'd1);
            write_param(SEL_MEAN, ch, 8'd0);
            write_param(SEL_BETA, ch, (ch < 2) ? 8'd0 : 8'd100);
        end
        wait_params_ready();
        send_sample(32'h807F_807F);
        send_sample(32'h7F80_7F80);
        send_sample(32'h0000_0000);
        send_burst(8);
        wait_drain();

        // zero stdv with either sign of gamma
        write_param(SEL_GAMMA, 0, 8'h28);
        write_param(SEL_GAMMA, 1, 8'hD8);
        write_param(SEL_GAMMA, 2, 8'h00);
        write_param(SEL_GAMMA, 3, 8'hFF);
        for (int ch = 0; ch < CH; ch++)
        begin
            write_param(SEL_STDV, ch, 8'd0);
            write_param(SEL_MEAN, ch, DW'(next_rand()));
        end
        wait_params_ready();
        send_burst(16);
        wait_drain();

        // gamma of channel 2 rewritten at fold start, mid fold and late fold
        write_param(SEL_STDV, 2, 8'd3);
        wait_params_ready();
        for (int i = 0; i < 3; i++)
        begin
            write_param(SEL_GAMMA, 2, DW'(next_rand()));
            idle(delays[i]);
            write_param(SEL_GAMMA, 2, DW'(next_rand()));
            wait_params_ready();
            send_burst(16);
            wait_drain();
        end

        // mean and beta alone never need a fold
        for (int ch = 0; ch < CH; ch++)
        begin
            write_param(SEL_MEAN, ch, DW'(next_rand()));
            assert (params_ready)
            else stop_on_error($sformatf("error at %0t ns: params_ready dropped after a mean write",
                $time));
            write_param(SEL_BETA, ch, DW'(next_rand()));
            assert (params_ready)
            else stop_on_error($sformatf("error at %0t ns: params_ready dropped after a beta write",
                $time));
        end
        idle(2);
        send_burst(16);
        wait_drain();

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// File: bn_batch_norm1d.f
src/bn_pkg.sv
src/bn_scale_divider.sv
src/bn_param_store.sv
src/bn_norm_lane.sv
src/bn_batch_norm1d.sv
verif/bn_batch_norm1d_props.sv
verif/bn_batch_norm1d_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator, verdict from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module bn_batch_norm1d_tb \
    -f bn_batch_norm1d.f -o bn_sim > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }
./obj_dir/bn_sim > sim.log 2>&1
grep -q "CHECKS FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "ALL CHECKS PASSED" sim.log || { echo "simulation ended early, see sim.log"; exit 1; }
echo "simulation passed"
exit 0
